// ==== logic/lc3b_pkg.sv ====
package lc3b_pkg;

	typedef logic [15:0] word_t;     // one machine word.
	typedef logic [2:0] reg_idx_t;   // picks one of the eight general registers.

	// Opcode values are the LC-3b encodings of ir[15:12].
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} opcode_t;

	localparam int NUM_OPERANDS = 3;   // sr1, sr2 and store data.
	localparam int OPND_SR1 = 0;
	localparam int OPND_SR2 = 1;
	localparam int OPND_STORE = 2;

	function automatic opcode_t get_opcode(input word_t ir);
		return opcode_t'(ir[15:12]);
	endfunction

	function automatic reg_idx_t get_dest(input word_t ir);
		return ir[11:9];   // dr for writers and sr for stores share these bits.
	endfunction

	// Only the register writers of this slice are listed here.
	function automatic logic writes_dest(input word_t ir);
		logic wr;
		case (get_opcode(ir))
			op_add, op_and, op_not, op_shf, op_lea: wr = 1'b1;
			default: wr = 1'b0;
		endcase
		return wr;
	endfunction

	function automatic logic is_imm_form(input word_t ir);
		return ir[5];   // add and and take imm5 when this bit is set.
	endfunction

endpackage

// ==== logic/reg_file.sv ====
module reg_file
(
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input lc3b_pkg::reg_idx_t wr_idx,
	input lc3b_pkg::word_t wr_data,
	input lc3b_pkg::reg_idx_t [lc3b_pkg::NUM_OPERANDS-1:0] rd_idx,

	output lc3b_pkg::word_t [lc3b_pkg::NUM_OPERANDS-1:0] rd_data
);
	import lc3b_pkg::*;

	word_t regs [8];   // r0 through r7.

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 8; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr_en)
		begin
			regs[wr_idx] <= wr_data;   // lands on the retiring edge.
		end
	end

	// Reads see the old value during a write; mem_wb forwarding covers that case.
	always_comb
	begin
		for (int p = 0; p < NUM_OPERANDS; p++)
		begin
			rd_data[p] = regs[rd_idx[p]];
		end
	end

endmodule : reg_file

// ==== logic/forwarding_logic.sv ====
module forwarding_logic
(
	input logic id_ex_valid,
	input lc3b_pkg::word_t id_ex_ir,
	input logic ex_mem_valid,
	input lc3b_pkg::word_t ex_mem_ir,
	input logic mem_wb_valid,
	input lc3b_pkg::word_t mem_wb_ir,

	output lc3b_pkg::reg_idx_t [lc3b_pkg::NUM_OPERANDS-1:0] src_idx,
	output logic [lc3b_pkg::NUM_OPERANDS-1:0] src_need,
	output lc3b_pkg::reg_idx_t ex_mem_dest,
	output logic ex_mem_dest_ok,
	output lc3b_pkg::reg_idx_t mem_wb_dest,
	output logic mem_wb_dest_ok
);
	import lc3b_pkg::*;

	opcode_t id_ex_op;

	assign id_ex_op = get_opcode(id_ex_ir);

	// The source fields sit at fixed positions in every format.
	assign src_idx[OPND_SR1] = id_ex_ir[8:6];
	assign src_idx[OPND_SR2] = id_ex_ir[2:0];
	assign src_idx[OPND_STORE] = id_ex_ir[11:9];

	always_comb
	begin
		src_need = '0;
		if (id_ex_valid)
		begin
			case (id_ex_op)
				op_add, op_and:
				begin
					src_need[OPND_SR1] = 1'b1;
					src_need[OPND_SR2] = !is_imm_form(id_ex_ir);   // imm5 form has no sr2.
				end
				op_not, op_shf:
				begin
					src_need[OPND_SR1] = 1'b1;
				end
				op_str:
				begin
					src_need[OPND_SR1] = 1'b1;     // base register.
					src_need[OPND_STORE] = 1'b1;   // the value being stored.
				end
				default:
				begin
					src_need = '0;   // lea and no-ops read no register.
				end
			endcase
		end
	end

	// Each older stage is judged once here and shared by all three operands.
	assign ex_mem_dest = get_dest(ex_mem_ir);
	assign ex_mem_dest_ok = ex_mem_valid && writes_dest(ex_mem_ir);

	assign mem_wb_dest = get_dest(mem_wb_ir);
	assign mem_wb_dest_ok = mem_wb_valid && writes_dest(mem_wb_ir);

endmodule : forwarding_logic

// ==== logic/operand_forward.sv ====
module operand_forward
(
	input lc3b_pkg::reg_idx_t src_idx,
	input logic src_need,
	input lc3b_pkg::reg_idx_t ex_mem_dest,
	input logic ex_mem_dest_ok,
	input lc3b_pkg::word_t ex_mem_val,
	input lc3b_pkg::reg_idx_t mem_wb_dest,
	input logic mem_wb_dest_ok,
	input lc3b_pkg::word_t mem_wb_val,
	input lc3b_pkg::word_t rf_val,

	output lc3b_pkg::word_t operand
);
	import lc3b_pkg::*;

	logic hit_ex_mem;
	logic hit_mem_wb;

	assign hit_ex_mem = src_need && ex_mem_dest_ok && (ex_mem_dest == src_idx);
	assign hit_mem_wb = src_need && mem_wb_dest_ok && (mem_wb_dest == src_idx);

	// The newest producer wins, so ex_mem is checked before mem_wb.
	always_comb
	begin
		if (hit_ex_mem)
			operand = ex_mem_val;
		else if (hit_mem_wb)
			operand = mem_wb_val;
		else
			operand = word_t'(rf_val);
	end

endmodule : operand_forward

// ==== logic/alu_execute.sv ====
module alu_execute
(
	input lc3b_pkg::word_t id_ex_ir,
	input lc3b_pkg::word_t id_ex_pc,
	input lc3b_pkg::word_t [lc3b_pkg::NUM_OPERANDS-1:0] operands,

	output lc3b_pkg::word_t ex_result,
	output lc3b_pkg::word_t ex_store_addr,
	output logic ex_is_store
);
	import lc3b_pkg::*;

	opcode_t op;
	word_t sr1;
	word_t imm5;
	word_t off6_x2;
	word_t off9_x2;
	word_t sr2_or_imm;
	logic [3:0] shamt;

	assign op = get_opcode(id_ex_ir);
	assign sr1 = operands[OPND_SR1];

	assign imm5 = {{11{id_ex_ir[4]}}, id_ex_ir[4:0]};
	assign off6_x2 = {{9{id_ex_ir[5]}}, id_ex_ir[5:0], 1'b0};   // word offset in bytes.
	assign off9_x2 = {{6{id_ex_ir[8]}}, id_ex_ir[8:0], 1'b0};
	assign sr2_or_imm = is_imm_form(id_ex_ir) ? imm5 : operands[OPND_SR2];
	assign shamt = id_ex_ir[3:0];

	assign ex_is_store = (op == op_str);
	assign ex_store_addr = sr1 + off6_x2;   // only meaningful for str.

	always_comb
	begin
		case (op)
			op_add: ex_result = sr1 + sr2_or_imm;
			op_and: ex_result = sr1 & sr2_or_imm;
			op_not: ex_result = ~sr1;
			op_shf:
			begin
				if (!id_ex_ir[4])
					ex_result = sr1 << shamt;
				else if (!id_ex_ir[5])
					ex_result = sr1 >> shamt;
				else
					ex_result = word_t'($signed(sr1) >>> shamt);   // keeps the sign bit.
			end
			op_lea: ex_result = id_ex_pc + 16'd2 + off9_x2;   // relative to the next pc.
			op_str: ex_result = operands[OPND_STORE];   // a store retires its data here.
			default:
			begin
				ex_result = '0;
			end
		endcase
	end

endmodule : alu_execute

// ==== logic/stage_control.sv ====
module stage_control
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input lc3b_pkg::word_t in_ir,
	input lc3b_pkg::word_t in_pc,
	input logic out_ready,
	input lc3b_pkg::word_t ex_result,
	input lc3b_pkg::word_t ex_store_addr,
	input logic ex_is_store,

	output logic in_ready,
	output logic id_ex_valid,
	output lc3b_pkg::word_t id_ex_ir,
	output lc3b_pkg::word_t id_ex_pc,
	output logic ex_mem_valid,
	output lc3b_pkg::word_t ex_mem_ir,
	output lc3b_pkg::word_t ex_mem_val,
	output logic mem_wb_valid,
	output lc3b_pkg::word_t mem_wb_ir,
	output lc3b_pkg::word_t mem_wb_val,
	output logic out_valid,
	output logic out_is_store,
	output lc3b_pkg::reg_idx_t out_dest,
	output lc3b_pkg::word_t out_value,
	output lc3b_pkg::word_t out_addr,
	output logic wr_en
);
	import lc3b_pkg::*;

	logic advance;
	logic accept;
	word_t ex_mem_addr;
	logic ex_mem_is_store;
	word_t mem_wb_addr;
	logic mem_wb_is_store;

	// The whole pipe moves together unless the retiring slot is blocked.
	assign advance = !mem_wb_valid || out_ready;
	assign in_ready = !id_ex_valid || advance;   // an empty id_ex can fill during a stall.
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			id_ex_valid <= 1'b0;
			ex_mem_valid <= 1'b0;
			mem_wb_valid <= 1'b0;
		end
		else
		begin
			if (advance)
			begin
				ex_mem_valid <= id_ex_valid;
				mem_wb_valid <= ex_mem_valid;
			end
			if (in_ready)
			begin
				id_ex_valid <= in_valid;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			id_ex_ir <= in_ir;
			id_ex_pc <= in_pc;
		end
		if (advance)
		begin
			ex_mem_ir <= id_ex_ir;
			ex_mem_val <= ex_result;
			ex_mem_addr <= ex_store_addr;
			ex_mem_is_store <= ex_is_store;
			mem_wb_ir <= ex_mem_ir;
			mem_wb_val <= ex_mem_val;
			mem_wb_addr <= ex_mem_addr;
			mem_wb_is_store <= ex_mem_is_store;
		end
	end

	// MEM_WB drives the output port directly, so it holds while stalled.
	assign out_valid = mem_wb_valid;
	assign out_is_store = mem_wb_is_store;
	assign out_dest = get_dest(mem_wb_ir);
	assign out_value = mem_wb_val;
	assign out_addr = mem_wb_addr;

	assign wr_en = mem_wb_valid && out_ready && writes_dest(mem_wb_ir);   // retiring edge.

endmodule : stage_control

// ==== logic/lc3b_fwd_core.sv ====
module lc3b_fwd_core
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input lc3b_pkg::word_t in_ir,
	input lc3b_pkg::word_t in_pc,
	input logic out_ready,

	output logic in_ready,
	output logic out_valid,
	output logic out_is_store,
	output lc3b_pkg::reg_idx_t out_dest,
	output lc3b_pkg::word_t out_value,
	output lc3b_pkg::word_t out_addr
);
	import lc3b_pkg::*;

	logic id_ex_valid;
	word_t id_ex_ir;
	word_t id_ex_pc;
	logic ex_mem_valid;
	word_t ex_mem_ir;
	word_t ex_mem_val;
	logic mem_wb_valid;
	word_t mem_wb_ir;
	word_t mem_wb_val;
	logic wr_en;

	reg_idx_t [NUM_OPERANDS-1:0] src_idx;
	logic [NUM_OPERANDS-1:0] src_need;
	reg_idx_t ex_mem_dest;
	logic ex_mem_dest_ok;
	reg_idx_t mem_wb_dest;
	logic mem_wb_dest_ok;

	word_t [NUM_OPERANDS-1:0] rf_data;
	word_t [NUM_OPERANDS-1:0] operands;
	word_t ex_result;
	word_t ex_store_addr;
	logic ex_is_store;

	stage_control u_stage_control (.*);

	// Retirement writes straight from the output fields.
	reg_file u_reg_file
	(
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(wr_en),
		.wr_idx(out_dest),
		.wr_data(out_value),
		.rd_idx(src_idx),
		.rd_data(rf_data)
	);

	forwarding_logic u_forwarding_logic (.*);

	for (genvar g = 0; g < NUM_OPERANDS; g++)
	begin : g_opnd
		operand_forward u_operand_forward
		(
			.src_idx(src_idx[g]),
			.src_need(src_need[g]),
			.ex_mem_dest(ex_mem_dest),
			.ex_mem_dest_ok(ex_mem_dest_ok),
			.ex_mem_val(ex_mem_val),
			.mem_wb_dest(mem_wb_dest),
			.mem_wb_dest_ok(mem_wb_dest_ok),
			.mem_wb_val(mem_wb_val),
			.rf_val(rf_data[g]),
			.operand(operands[g])
		);
	end

	alu_execute u_alu_execute (.*);

endmodule : lc3b_fwd_core

// ==== test/tb_checker.sv ====
module tb_checker
#(
	parameter int max_cycles = 1000
)
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_ready,
	input lc3b_pkg::word_t in_ir,
	input lc3b_pkg::word_t in_pc,
	input logic out_ready,
	input logic out_valid,
	input logic out_is_store,
	input lc3b_pkg::reg_idx_t out_dest,
	input lc3b_pkg::word_t out_value,
	input lc3b_pkg::word_t out_addr,
	input int test_id,

	output int accepted,
	output int retired,
	output int err_count,
	output int failed_tests,
	output logic timed_out,
	output logic report_done
);
	import lc3b_pkg::*;

	word_t model_regs [8];   // architectural state in program order.
	int exp_kind [$];        // 0 no-op, 1 register write, 2 store.
	reg_idx_t exp_dest [$];
	word_t exp_value [$];
	word_t exp_addr [$];
	int exp_cycle [$];
	int cycle;
	int cur_test;
	int test_errs;
	int test_start;
	int tests_run;
	logic rst_seen;
	logic held;
	logic held_store;
	reg_idx_t held_dest;
	word_t held_value;
	word_t held_addr;

	function automatic string test_name(input int id);
		case (id)
			0: return "reset";
			1: return "reg_forward";
			2: return "store_forward";
			3: return "imm_shift_lea";
			4: return "back_pressure";
			5: return "latency";
			default: return "end";
		endcase
	endfunction

	task automatic compare(input string what, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			$display("Error [%s] %s: expected %h, actual %h",
				test_name(cur_test), what, expected, actual);
			err_count++;
			test_errs++;
		end
	endtask

	task automatic model_accept(input word_t ir, input word_t pc);
		word_t a;
		word_t b;
		word_t res;
		word_t addr;
		int kind;
		a = model_regs[ir[8:6]];
		b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : model_regs[ir[2:0]];
		res = '0;
		addr = '0;
		kind = 1;
		case (opcode_t'(ir[15:12]))
			op_add: res = a + b;
			op_and: res = a & b;
			op_not: res = ~a;
			op_shf:
			begin
				res = a;
				repeat (ir[3:0])   // one bit per step; the fill bit is the sign only for arithmetic.
					res = !ir[4] ? {res[14:0], 1'b0} : {ir[5] & res[15], res[15:1]};
			end
			op_lea: res = pc + 16'd2 + {{6{ir[8]}}, ir[8:0], 1'b0};
			op_str:
			begin
				kind = 2;
				res = model_regs[ir[11:9]];
				addr = a + {{9{ir[5]}}, ir[5:0], 1'b0};
			end
			default: kind = 0;
		endcase
		if (kind == 1)
			model_regs[ir[11:9]] = res;
		exp_kind.push_back(kind);
		exp_dest.push_back(ir[11:9]);
		exp_value.push_back(res);
		exp_addr.push_back(addr);
		exp_cycle.push_back(cycle);
		accepted++;
	endtask

	task automatic check_retire();
		int kind;
		reg_idx_t dest;
		word_t value;
		word_t addr;
		int acc_cycle;
		if (exp_kind.size() == 0)
		begin
			$display("[%s] the DUT retired an instruction that was never accepted",
				test_name(cur_test));
			err_count++;
			test_errs++;
		end
		else
		begin
			kind = exp_kind.pop_front();
			dest = exp_dest.pop_front();
			value = exp_value.pop_front();
			addr = exp_addr.pop_front();
			acc_cycle = exp_cycle.pop_front();
			compare("out_is_store", word_t'(kind == 2), word_t'(out_is_store));
			if (kind == 1)
			begin
				compare("out_dest", word_t'(dest), word_t'(out_dest));
				compare("out_value", value, out_value);
			end
			if (kind == 2)
			begin
				compare("store data", value, out_value);
				compare("store address", addr, out_addr);
			end
			if (cur_test == 5)
				compare("retire latency", 16'd3, word_t'(cycle - acc_cycle));
		end
		retired++;
	endtask

	task automatic close_test();
		tests_run++;
		if (test_errs != 0)
			failed_tests++;
		$display("%s: %0d instructions retired, %0d errors, %s", test_name(cur_test),
			retired - test_start, test_errs, (test_errs == 0) ? "passed" : "failed");
		cur_test = test_id;
		test_errs = 0;
		test_start = retired;
		if (test_id == 6)
		begin
			$display("summary: %0d tests run, %0d failed, %0d accepted, %0d retired, %0d errors",
				tests_run, failed_tests, accepted, retired, err_count);
			report_done = 1'b1;
		end
	endtask

	initial
	begin
		cycle = 0;
		timed_out = 1'b0;
		forever
		begin
			@(posedge clk);
			cycle++;
			if (cycle >= max_cycles && !timed_out)
			begin
				$display("timeout: the run did not finish in %0d cycles, %0d accepted, %0d retired",
					cycle, accepted, retired);
				timed_out = 1'b1;
			end
		end
	end

	// Everything is sampled at the falling edge, half a cycle from any change.
	initial
	begin
		for (int i = 0; i < 8; i++)
			model_regs[i] = '0;
		accepted = 0;
		retired = 0;
		err_count = 0;
		failed_tests = 0;
		report_done = 1'b0;
		cur_test = 0;
		test_errs = 0;
		test_start = 0;
		tests_run = 0;
		rst_seen = 1'b0;
		held = 1'b0;
		forever
		begin
			@(negedge clk);
			if (test_id != cur_test)
				close_test();
			if (!rst_n || !rst_seen)
			begin
				compare("out_valid in reset", 16'd0, word_t'(out_valid));
				compare("in_ready in reset", 16'd1, word_t'(in_ready));
			end
			rst_seen = rst_n;
			if (held)
			begin
				compare("out_valid while stalled", 16'd1, word_t'(out_valid));
				compare("out_is_store while stalled", word_t'(held_store), word_t'(out_is_store));
				compare("out_dest while stalled", word_t'(held_dest), word_t'(out_dest));
				compare("out_value while stalled", held_value, out_value);
				compare("out_addr while stalled", held_addr, out_addr);
			end
			held = rst_n && out_valid && !out_ready;
			held_store = out_is_store;
			held_dest = out_dest;
			held_value = out_value;
			held_addr = out_addr;
			if (rst_n && in_valid && in_ready)
				model_accept(in_ir, in_pc);
			if (rst_n && out_valid && out_ready)
				check_retire();
		end
	end

endmodule : tb_checker

// ==== test/tb_top.sv ====
module tb_top;
	import lc3b_pkg::*;

	localparam int num_instr = 755;   // reset 5, then 200, 150, 150, 200 and 50.
	localparam int max_cycles = 8 * num_instr + 100;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	word_t in_ir;
	word_t in_pc;
	logic out_ready;
	logic out_valid;
	logic out_is_store;
	reg_idx_t out_dest;
	word_t out_value;
	word_t out_addr;
	logic random_ready;
	int test_id;
	int accepted;
	int retired;
	int err_count;
	int failed_tests;
	logic timed_out;
	logic report_done;

	lc3b_fwd_core u_dut (.*);

	tb_checker #(.max_cycles(max_cycles)) u_checker (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// The sink takes about two results in three while back-pressure is on.
	always @(posedge clk)
	begin
		#2;
		out_ready = random_ready ? ($urandom_range(0, 2) != 0) : 1'b1;
	end

	function automatic reg_idx_t near_reg();
		return reg_idx_t'($urandom_range(0, 3));   // a small set keeps producers close.
	endfunction

	function automatic logic [3:0] random_op(input logic writer);
		word_t probe;
		probe = word_t'($urandom());
		while (writes_dest(probe) != writer || probe[15:12] == op_str)
			probe = word_t'($urandom());
		return probe[15:12];
	endfunction

	function automatic word_t pick_instr(input int kind);
		word_t ir;
		logic [3:0] op;
		ir = word_t'($urandom());
		case (kind)
			2:
			begin
				op = ($urandom_range(0, 1) == 0) ? 4'(op_str) : random_op(1'b1);
				ir = {op, near_reg(), near_reg(), ir[5:0]};
			end
			3:
			begin
				case ($urandom_range(0, 4))
					0: ir = {4'(op_add), ir[11:6], 1'b1, ir[4:0]};
					1: ir = {4'(op_and), ir[11:6], 1'b1, ir[4:0]};
					2: ir[15:12] = op_shf;
					3: ir[15:12] = op_lea;
					default: ir[15:12] = random_op(1'b0);   // retires as a no-op.
				endcase
			end
			4: ir = word_t'($urandom());   // a raw word reaches every opcode.
			default:
			begin
				case ($urandom_range(0, 2))
					0: op = op_add;
					1: op = op_and;
					default: op = op_not;
				endcase
				ir = {op, near_reg(), near_reg(), 3'b000, near_reg()};
			end
		endcase
		return ir;
	endfunction

	task automatic send_instr(input word_t ir);
		logic taken;
		in_valid = 1'b1;
		in_ir = ir;
		in_pc = word_t'($urandom() & 32'h0000_fffe);
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk);
			taken = in_ready;
			@(posedge clk);
			#2;
		end
	endtask

	task automatic drain();
		in_valid = 1'b0;
		while (retired != accepted)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic run_test(input int id, input int count, input logic gaps);
		test_id = id;
		random_ready <= gaps;
		repeat (count)
		begin
			if (gaps && $urandom_range(0, 3) == 0)
			begin
				in_valid = 1'b0;
				@(posedge clk);
				#2;
			end
			send_instr(pick_instr(id));
		end
		random_ready <= 1'b0;
		drain();
	endtask

	initial
	begin
		void'($urandom(98534));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_ir = '0;
		in_pc = '0;
		out_ready = 1'b1;
		random_ready = 1'b0;
		test_id = 0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		send_instr({4'(op_add), 3'd0, 3'd1, 3'b000, 3'd2});
		send_instr({4'(op_and), 3'd0, 3'd4, 3'b000, 3'd5});
		send_instr({4'(op_str), 3'd6, 3'd7, 6'd1});
		send_instr({4'(op_not), 3'd4, 3'd3, 6'h3f});
		send_instr({4'(op_add), 3'd1, 3'd4, 1'b1, 5'd3});   // r4 comes from a forward.
		drain();
		run_test(1, 200, 1'b0);
		run_test(2, 150, 1'b0);
		run_test(3, 150, 1'b0);
		run_test(4, 200, 1'b1);
		run_test(5, 50, 1'b0);
		test_id = 6;   // closes the last test in the checker.
		wait (report_done);
		if (failed_tests == 0 && err_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial
	begin
		wait (timed_out);
		$display("tests failed");
		$finish;
	end

endmodule : tb_top

// ==== files.f ====
logic/lc3b_pkg.sv
logic/reg_file.sv
logic/forwarding_logic.sv
logic/operand_forward.sv
logic/alu_execute.sv
logic/stage_control.sv
logic/lc3b_fwd_core.sv
test/tb_checker.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --top-module tb_top -f files.f --Mdir obj_dir -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -qx "all tests passed"
then
	exit 0
fi
exit 1
